// File: regex_pkg.sv
package regex_pkg;

   // Stream id space
   localparam int STREAM_W   = 6;
   localparam int NUM_STREAM = 1 << STREAM_W;

   // Categories: 0 looks for "SSH-", 1 looks for "GET /"
   localparam int NUM_CAT = 2;
   localparam int CAT_W   = 1;

   // Matcher state, wide enough for patterns up to 7 bytes
   localparam int STATE_W = 3;
   localparam int PAT_MAX = 7;

   // Per stream and category hit counters, wrap at 16 bits
   localparam int COUNT_W = 16;

   // Pattern length per category, index 0 in the low slice
   localparam logic [NUM_CAT-1:0][STATE_W-1:0] PAT_LEN_TABLE = {
      3'd5,
      3'd4
   };

   // Pattern bytes per category, byte 0 is the first byte to match
   // Unused tail bytes are zero and never reached
   localparam logic [NUM_CAT-1:0][PAT_MAX-1:0][7:0] PAT_BYTE_TABLE = {
      // "GET /"
      {8'h00, 8'h00, 8'h2f, 8'h20, 8'h54, 8'h45, 8'h47},
      // "SSH-"
      {8'h00, 8'h00, 8'h00, 8'h2d, 8'h48, 8'h53, 8'h53}
   };

   // Commit request from a tracker to the count table
   typedef struct packed {
      logic [STREAM_W-1:0] stream;
      // Add one when set, otherwise a commit without a hit
      logic                inc;
   } hit_req_t;

endpackage

// File: pkt_bus_if.sv
`timescale 1ns/1ps

interface pkt_bus_if
   import regex_pkg::*;
();

   // Packet open pulse and the context that goes with it
   logic                start;
   logic [STREAM_W-1:0] stream_id;
   logic                new_stream;
   logic [NUM_CAT-1:0]  enable;

   // Byte stream, already qualified with the ready side
   logic                byte_valid;
   logic [7:0]          byte_data;
   logic                eop;

   // Top level side
   modport source (output start, stream_id, new_stream, enable, byte_valid, byte_data, eop);

   // Tracker side
   modport sink (input start, stream_id, new_stream, enable, byte_valid, byte_data, eop);

endinterface

// File: string_dfa.sv
`timescale 1ns/1ps

module string_dfa
   import regex_pkg::*;
#(
   parameter int CAT = 0
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               byte_valid,
   input  logic [7:0]         byte_data,
   input  logic               state_load,
   input  logic [STATE_W-1:0] load_value,
   output logic [STATE_W-1:0] state,
   output logic               accept
);

   logic [7:0]         exp_byte;
   logic [7:0]         first_byte;
   logic [STATE_W-1:0] step;
   logic [STATE_W-1:0] next_state;
   logic               done;

   // Next state for the current byte
   always_comb
   begin
      exp_byte   = PAT_BYTE_TABLE[CAT][state];
      first_byte = PAT_BYTE_TABLE[CAT][0];
      step       = state + 1'b1;
      done       = 1'b0;
      if (byte_data == exp_byte)
      begin
         // Last byte of the pattern wraps back to idle
         if (step == PAT_LEN_TABLE[CAT])
         begin
            next_state = '0;
            done       = 1'b1;
         end
         else
         begin
            next_state = step;
         end
      end
      // Mismatch may still restart the pattern
      else if (byte_data == first_byte)
         next_state = STATE_W'(1);
      else
         next_state = '0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state  <= '0;
         accept <= 1'b0;
      end
      else
      begin
         accept <= 1'b0;
         // Restore has priority, no byte arrives in that cycle anyway
         if (state_load)
            state <= load_value;
         else if (byte_valid)
         begin
            state  <= next_state;
            accept <= done;
         end
      end
   end

endmodule

// File: category_tracker.sv
`timescale 1ns/1ps

module category_tracker
   import regex_pkg::*;
#(
   parameter int CAT = 0
) (
   input  logic     clk,
   input  logic     rst_n,
   pkt_bus_if.sink  pkt,
   input  logic     hit_ready,
   output logic     hit_valid,
   output hit_req_t hit_req
);

   // Saved matcher state per stream
   logic [STATE_W-1:0]  ctx_mem [NUM_STREAM];

   // Context of the open packet
   logic [STREAM_W-1:0] cur_stream;
   logic                cur_en;

   // Restore stage
   logic                load_q;
   logic [STATE_W-1:0]  load_val;

   logic                eop_byte;
   logic                eop_d1;
   logic                spec_hit;
   logic [STATE_W-1:0]  dfa_state;
   logic                dfa_accept;

   assign eop_byte = pkt.byte_valid & pkt.eop;

   string_dfa #(
      .CAT (CAT)
   ) i_string_dfa (
      .clk        (clk),
      .rst_n      (rst_n),
      .byte_valid (pkt.byte_valid),
      .byte_data  (pkt.byte_data),
      .state_load (load_q),
      .load_value (load_val),
      .state      (dfa_state),
      .accept     (dfa_accept)
   );

   // Control flags
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         load_q    <= 1'b0;
         eop_d1    <= 1'b0;
         spec_hit  <= 1'b0;
         cur_en    <= 1'b0;
         hit_valid <= 1'b0;
      end
      else
      begin
         load_q <= pkt.start;
         // Accept for the eop byte shows up one cycle later
         eop_d1 <= eop_byte;
         // At most one hit per packet
         if (dfa_accept)
            spec_hit <= 1'b1;
         // Cleared on open and after commit, disabled tracker drops it here
         if (pkt.start || eop_d1)
            spec_hit <= 1'b0;
         if (pkt.start)
            cur_en <= pkt.enable[CAT];
         if (hit_valid && hit_ready)
            hit_valid <= 1'b0;
         // Only an enabled tracker commits
         if (eop_d1 && cur_en)
            hit_valid <= 1'b1;
      end
   end

   // Context restore, save and request payload
   always_ff @(posedge clk)
   begin
      if (pkt.start)
      begin
         cur_stream <= pkt.stream_id;
         if (pkt.new_stream)
            load_val <= '0;
         // Same stream reopened while its state is being saved
         else if (eop_d1 && cur_en && (pkt.stream_id == cur_stream))
            load_val <= dfa_state;
         else
            load_val <= ctx_mem[pkt.stream_id];
      end
      if (eop_d1 && cur_en)
      begin
         // Payload held until the table grants it
         hit_req.stream       <= cur_stream;
         hit_req.inc          <= spec_hit | dfa_accept;
         ctx_mem[cur_stream]  <= dfa_state;
      end
   end

endmodule

// File: hit_count_table.sv
`timescale 1ns/1ps

module hit_count_table
   import regex_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic     [NUM_CAT-1:0]       hit_valid,
   input  hit_req_t [NUM_CAT-1:0]       hit_req,
   input  logic     [STREAM_W-1:0]      rd_stream,
   input  logic     [CAT_W-1:0]         rd_cat,
   output logic     [NUM_CAT-1:0]       hit_ready,
   output logic     [COUNT_W-1:0]       rd_count
);

   // Count storage per category and stream
   logic [COUNT_W-1:0]                  cnt_mem [NUM_CAT][NUM_STREAM];
   // Entry written since reset, unwritten entries read as zero
   logic [NUM_CAT-1:0][NUM_STREAM-1:0]  cnt_vld;

   // Arbiter
   logic [CAT_W-1:0]                    rr_ptr;
   logic [CAT_W-1:0]                    gnt_idx;
   logic                                gnt_any;
   hit_req_t                            gnt_req;
   logic [COUNT_W-1:0]                  base;

   always_comb
   begin
      gnt_any = |hit_valid;
      // Both requesting, the pointer picks
      if (&hit_valid)
         gnt_idx = rr_ptr;
      else if (hit_valid[1])
         gnt_idx = CAT_W'(1);
      else
         gnt_idx = '0;
      hit_ready = '0;
      if (gnt_any)
         hit_ready[gnt_idx] = 1'b1;
      gnt_req = hit_req[gnt_idx];
      // Current value of the entry being updated
      if (cnt_vld[gnt_idx][gnt_req.stream])
         base = cnt_mem[gnt_idx][gnt_req.stream];
      else
         base = '0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rr_ptr   <= '0;
         cnt_vld  <= '0;
         rd_count <= '0;
      end
      else
      begin
         if (gnt_any)
         begin
            // Other tracker wins next time
            rr_ptr                           <= ~gnt_idx;
            cnt_vld[gnt_idx][gnt_req.stream] <= 1'b1;
         end
         // Registered read port
         if (cnt_vld[rd_cat][rd_stream])
            rd_count <= cnt_mem[rd_cat][rd_stream];
         else
            rd_count <= '0;
      end
   end

   // Update in the grant cycle, wraps on overflow
   always_ff @(posedge clk)
   begin
      if (gnt_any)
         cnt_mem[gnt_idx][gnt_req.stream] <= base + COUNT_W'(gnt_req.inc);
   end

endmodule

// File: scan_top.sv
`timescale 1ns/1ps

module scan_top
   import regex_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                pkt_start,
   input  logic [STREAM_W-1:0] stream_id,
   input  logic                new_stream,
   input  logic [NUM_CAT-1:0]  enable,
   input  logic                char_valid,
   input  logic [7:0]          char_data,
   input  logic                char_eop,
   input  logic [STREAM_W-1:0] rd_stream,
   input  logic [CAT_W-1:0]    rd_cat,
   output logic                char_ready,
   output logic [COUNT_W-1:0]  rd_count
);

   pkt_bus_if pkt ();

   logic                       pkt_open;
   logic                       restore;
   logic                       start;
   logic     [NUM_CAT-1:0]     hit_valid;
   logic     [NUM_CAT-1:0]     hit_ready;
   hit_req_t [NUM_CAT-1:0]     hit_req;

   // New packet only when none is open
   assign start = pkt_start & ~pkt_open;

   // Stall for the restore cycle and for any pending commit
   assign char_ready = pkt_open & ~restore & ~(|hit_valid);

   // Packet bus towards the trackers
   assign pkt.start      = start;
   assign pkt.stream_id  = stream_id;
   assign pkt.new_stream = new_stream;
   assign pkt.enable     = enable;
   assign pkt.byte_valid = char_valid & char_ready;
   assign pkt.byte_data  = char_data;
   assign pkt.eop        = char_eop;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pkt_open <= 1'b0;
         restore  <= 1'b0;
      end
      else
      begin
         // Trackers restore context in the cycle after start
         restore <= start;
         if (start)
            pkt_open <= 1'b1;
         else if (pkt.byte_valid && char_eop)
            pkt_open <= 1'b0;
      end
   end

   for (genvar c = 0; c < NUM_CAT; c++)
   begin : g_cat
      category_tracker #(
         .CAT (c)
      ) i_category_tracker (
         .clk       (clk),
         .rst_n     (rst_n),
         .pkt       (pkt),
         .hit_ready (hit_ready[c]),
         .hit_valid (hit_valid[c]),
         .hit_req   (hit_req[c])
      );
   end

   hit_count_table i_hit_count_table (
      .clk       (clk),
      .rst_n     (rst_n),
      .hit_valid (hit_valid),
      .hit_req   (hit_req),
      .rd_stream (rd_stream),
      .rd_cat    (rd_cat),
      .hit_ready (hit_ready),
      .rd_count  (rd_count)
   );

endmodule

// File: tb_scan_top.sv
`timescale 1ns/1ps

module tb_scan_top
   import regex_pkg::*;
();

   typedef logic [7:0] byte_q_t [$];

   // Packet counts and sizes that set the run limit
   localparam int DIR_PKTS     = 9;
   localparam int DIR_BYTES    = 47;
   localparam int RAND_PKTS    = 40;
   localparam int RAND_MAX_LEN = 16;
   localparam int TIMEOUT_CYC  = DIR_BYTES + (RAND_PKTS + 8) * RAND_MAX_LEN
                                 + 40 * (DIR_PKTS + RAND_PKTS + 8);

   logic                  clk;
   logic                  rst_n;
   logic                  pkt_start;
   logic [STREAM_W-1:0]   stream_id;
   logic                  new_stream;
   logic [NUM_CAT-1:0]    enable;
   logic                  char_valid;
   logic [7:0]            char_data;
   logic                  char_eop;
   logic [STREAM_W-1:0]   rd_stream;
   logic [CAT_W-1:0]      rd_cat;
   logic                  char_ready;
   logic [COUNT_W-1:0]    rd_count;

   // Reference model with expected counts and saved matcher state
   logic [COUNT_W-1:0]    exp_cnt  [NUM_CAT][NUM_STREAM];
   logic [STATE_W-1:0]    saved_st [NUM_CAT][NUM_STREAM];
   // Streams used by the running test
   logic [NUM_STREAM-1:0] touched;

   logic [31:0]           lfsr_q;
   int                    errors;
   int                    checks;
   int                    tests;
   int                    test_err_base;
   event                  check_start;
   event                  check_end;

   scan_top i_scan_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .pkt_start  (pkt_start),
      .stream_id  (stream_id),
      .new_stream (new_stream),
      .enable     (enable),
      .char_valid (char_valid),
      .char_data  (char_data),
      .char_eop   (char_eop),
      .rd_stream  (rd_stream),
      .rd_cat     (rd_cat),
      .char_ready (char_ready),
      .rd_count   (rd_count)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         val    = {val[30:0], lfsr_q[0]};
      end
   endtask

   // Scan one packet from a start state and return {hit, final state}
   function automatic logic [STATE_W:0] ref_scan(input int cat, input logic [STATE_W-1:0] st0,
                                                 input byte_q_t data);
      string pat;
      int    st;
      logic  hit;
      if (cat == 0)
         pat = "SSH-";
      else
         pat = "GET /";
      st  = st0;
      hit = 1'b0;
      foreach (data[i])
      begin
         if (data[i] == pat[st])
         begin
            st++;
            if (st == pat.len())
            begin
               hit = 1'b1;
               st  = 0;
            end
         end
         // Mismatch restarts on the first pattern byte
         else if (data[i] == pat[0])
            st = 1;
         else
            st = 0;
      end
      return {hit, st[STATE_W-1:0]};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   // Called on a falling edge with no packet open
   task automatic send_packet(input logic [STREAM_W-1:0] stream, input logic fresh,
                              input logic [NUM_CAT-1:0] en, input byte_q_t data);
      logic [STATE_W-1:0] start_st;
      logic [STATE_W:0]   res;
      pkt_start  = 1'b1;
      stream_id  = stream;
      new_stream = fresh;
      enable     = en;
      @(negedge clk);
      pkt_start  = 1'b0;
      // Context restore cycle keeps bytes out
      check_value("char_ready", 32'(char_ready), 32'h0);
      foreach (data[i])
      begin
         char_valid = 1'b1;
         char_data  = data[i];
         char_eop   = (i == data.size() - 1);
         // Hold the byte through restore and commit stalls
         while (!char_ready)
            @(negedge clk);
         @(negedge clk);
      end
      char_valid      = 1'b0;
      char_eop        = 1'b0;
      touched[stream] = 1'b1;
      // Disabled category neither counts nor saves its state
      for (int c = 0; c < NUM_CAT; c++)
      begin
         start_st = fresh ? '0 : saved_st[c][stream];
         res      = ref_scan(c, start_st, data);
         if (en[c])
         begin
            saved_st[c][stream] = res[STATE_W-1:0];
            exp_cnt[c][stream]  = exp_cnt[c][stream] + COUNT_W'(res[STATE_W]);
         end
      end
   endtask

   task automatic send_text(input logic [STREAM_W-1:0] stream, input logic fresh,
                            input logic [NUM_CAT-1:0] en, input string text);
      byte_q_t data;
      for (int i = 0; i < text.len(); i++)
         data.push_back(text[i]);
      send_packet(stream, fresh, en, data);
   endtask

   // Bytes drawn from the pattern alphabet so hits happen often
   task automatic send_random(input logic [STREAM_W-1:0] stream, input logic fresh,
                              input logic [NUM_CAT-1:0] en, input int len);
      byte_q_t     data;
      logic [31:0] pick;
      string       alphabet;
      alphabet = "SH-GET /";
      for (int i = 0; i < len; i++)
      begin
         take_bits(3, pick);
         data.push_back(alphabet[pick]);
      end
      send_packet(stream, fresh, en, data);
   endtask

   task automatic open_test();
      touched       = '0;
      test_err_base = errors;
   endtask

   task automatic finish_test(input string name);
      -> check_start;
      @(check_end);
      tests++;
      if (errors == test_err_base)
         $display("test %0d %s: ok", tests, name);
      else
         $display("test %0d %s: %0d errors", tests, name, errors - test_err_base);
   endtask

   // Readback of every touched count once the commits have drained
   initial
   begin
      rd_stream = '0;
      rd_cat    = '0;
      forever
      begin
         @(check_start);
         repeat (6) @(negedge clk);
         for (int s = 0; s < NUM_STREAM; s++)
            for (int c = 0; c < NUM_CAT; c++)
               if (touched[s])
               begin
                  rd_stream = STREAM_W'(s);
                  rd_cat    = CAT_W'(c);
                  @(negedge clk);
                  check_value($sformatf("rd_count[cat %0d][stream %0d]", c, s),
                              32'(rd_count), 32'(exp_cnt[c][s]));
               end
         -> check_end;
      end
   end

   initial
   begin
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYC)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
   end

   initial
   begin
      logic [31:0] sel;
      logic [31:0] en_bits;
      logic [31:0] new_bits;
      logic [31:0] len_bits;
      rst_n      = 1'b0;
      pkt_start  = 1'b0;
      stream_id  = '0;
      new_stream = 1'b0;
      enable     = '0;
      char_valid = 1'b0;
      char_data  = '0;
      char_eop   = 1'b0;
      lfsr_q     = 32'hc476_75a5;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      for (int c = 0; c < NUM_CAT; c++)
         for (int s = 0; s < NUM_STREAM; s++)
         begin
            exp_cnt[c][s]  = '0;
            saved_st[c][s] = '0;
         end
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      open_test();
      // No packet open after reset so no byte is taken
      check_value("char_ready", 32'(char_ready), 32'h0);
      touched = '1;
      finish_test("reset counts");

      // One hit per packet even with two matches
      open_test();
      send_text(1, 1'b1, 2'b11, "xxSSH-yy");
      send_text(2, 1'b1, 2'b11, "GET /a GET /b");
      finish_test("single hit per packet");

      // Split match and then the same split on a fresh stream
      open_test();
      send_text(3, 1'b1, 2'b11, "abcGET");
      send_text(3, 1'b0, 2'b11, " /xyz");
      send_text(4, 1'b1, 2'b11, "GET");
      send_text(4, 1'b1, 2'b11, " /");
      finish_test("match across packets");

      // Category 0 off in the middle packet keeps its state from the first
      open_test();
      send_text(5, 1'b1, 2'b11, "SS");
      send_text(5, 1'b0, 2'b10, "xSSH-x");
      send_text(5, 1'b0, 2'b11, "H-");
      finish_test("disabled category");

      // Streams 8 to 15 open fresh and fully enabled before the random mix
      open_test();
      for (int s = 8; s < 16; s++)
      begin
         take_bits(4, len_bits);
         send_random(STREAM_W'(s), 1'b1, 2'b11, int'(len_bits) + 1);
      end
      for (int p = 0; p < RAND_PKTS; p++)
      begin
         take_bits(3, sel);
         take_bits(2, en_bits);
         take_bits(3, new_bits);
         take_bits(4, len_bits);
         send_random(STREAM_W'(8 + sel), new_bits == 0, en_bits[1:0], int'(len_bits) + 1);
      end
      finish_test("random packets");

      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// File: compile.f
regex_pkg.sv
pkt_bus_if.sv
string_dfa.sv
category_tracker.sv
hit_count_table.sv
scan_top.sv
tb_scan_top.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and grep the log for the pass line
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_scan_top -f compile.f \
   && ./obj_dir/Vtb_scan_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^TEST PASS$' sim.log 2>/dev/null && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }
